// File: iigs_glue_pkg.sv
`default_nettype none

package iigs_glue_pkg;

  // wishbone classic request from the master
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [23:0] adr;
    logic [7:0]  dat;
  } wb_req_t;

  // one IO access, wr/rd strobes last a single cycle
  typedef struct packed {
    logic       wr;
    logic       rd;
    logic [7:0] off;  // low byte of the C0xx address
    logic [7:0] data;
  } io_acc_t;

  typedef struct packed {
    logic       hit;
    logic [7:0] data;
  } io_rsp_t;

  typedef struct packed {
    logic store80;
    logic ramrd;
    logic ramwrt;
    logic altzp;
    logic page2;
    logic hires;
    logic textg;
    logic mixg;
    logic eightycol;
    logic altcharset;
    logic intcxrom;
    logic slotc3rom;
    logic rombank;
  } mem_mode_t;

  typedef struct packed {
    logic rdrom;   // read ROM instead of LC RAM
    logic lcram2;  // bank 2 selected at D000
    logic lc_we;
  } lc_ctl_t;

  typedef struct packed {
    logic [23:0] phys_addr;
    logic        io;
    logic        lc_we;
  } mem_out_t;

  typedef enum logic [1:0] {
    lc_protect,
    lc_armed,   // one odd read seen
    lc_write
  } lc_state_e;

  typedef enum logic [7:0] {
    REG_STORE80_OFF = 8'h00, REG_STORE80_ON = 8'h01,
    REG_RAMRD_OFF   = 8'h02, REG_RAMRD_ON   = 8'h03,
    REG_RAMWRT_OFF  = 8'h04, REG_RAMWRT_ON  = 8'h05,
    REG_INTCX_OFF   = 8'h06, REG_INTCX_ON   = 8'h07,
    REG_ALTZP_OFF   = 8'h08, REG_ALTZP_ON   = 8'h09,
    REG_SLOTC3_OFF  = 8'h0A, REG_SLOTC3_ON  = 8'h0B,
    REG_80COL_OFF   = 8'h0C, REG_80COL_ON   = 8'h0D,
    REG_ALTCHR_OFF  = 8'h0E, REG_ALTCHR_ON  = 8'h0F,
    REG_VGCINT      = 8'h23,
    REG_VGCCLR      = 8'h32,
    REG_SHADOW      = 8'h35,
    REG_INTEN       = 8'h41,
    REG_INTFLAG     = 8'h46,
    REG_INTCLR      = 8'h47,
    REG_TEXT_OFF    = 8'h50, REG_TEXT_ON    = 8'h51,
    REG_MIXED_OFF   = 8'h52, REG_MIXED_ON   = 8'h53,
    REG_PAGE2_OFF   = 8'h54, REG_PAGE2_ON   = 8'h55,
    REG_HIRES_OFF   = 8'h56, REG_HIRES_ON   = 8'h57,
    REG_STATE       = 8'h68,
    REG_LC_BASE     = 8'h80
  } io_reg_e;

  localparam logic [7:0]  IO_PAGE       = 8'hC0;
  localparam logic [15:0] LC_LO         = 16'hD000;
  localparam logic [15:0] LC_HI         = 16'hDFFF;
  localparam logic [23:0] LC_OFFSET     = 24'h001000;
  localparam logic [23:0] AUX_OFFSET    = 24'h010000;
  localparam logic [7:0]  BANK_MAIN     = 8'h00;
  localparam logic [7:0]  BANK_MAIN1    = 8'h01;
  localparam logic [7:0]  BANK_MEGA     = 8'hE0;
  localparam logic [7:0]  BANK_MEGA1    = 8'hE1;
  localparam int          SHADOW_IO_BIT = 6;
  localparam logic [7:0]  SHADOW_RESET  = 8'h08;

  localparam int QTR_TICK_CYCLES = 64;  // small for simulation
  localparam int QTRS_PER_SECOND = 4;

  typedef logic [$clog2(QTR_TICK_CYCLES)-1:0] qtr_cnt_t;

endpackage

`default_nettype wire

// File: wb_io_port.sv
`timescale 1ns/1ns
`default_nettype none

module wb_io_port (
  input  wire logic                    clk_sys,
  input  wire logic                    cpu_vda,
  input  wire iigs_glue_pkg::wb_req_t  wb,
  input  wire logic [7:0]              shadow,
  input  wire iigs_glue_pkg::io_rsp_t  rsp_sw,
  input  wire iigs_glue_pkg::io_rsp_t  rsp_lc,
  input  wire iigs_glue_pkg::io_rsp_t  rsp_irq,
  output iigs_glue_pkg::io_acc_t       acc,
  output logic [7:0]                   wb_dat,
  output logic                         wb_ack,
  output logic                         io
);
  import iigs_glue_pkg::*;

  logic       req;      // request not yet acknowledged
  logic       bank_ok;
  logic       io_addr;
  logic [7:0] rd_data;

  assign req     = wb.cyc & wb.stb & ~wb_ack;
  assign bank_ok = wb.adr[23:16] inside {BANK_MAIN, BANK_MAIN1, BANK_MEGA, BANK_MEGA1};
  // C0xx page, unless IO is shadowed out
  assign io_addr = bank_ok & (wb.adr[15:8] == IO_PAGE) & ~shadow[SHADOW_IO_BIT];
  assign io      = wb.cyc & wb.stb & io_addr;

  assign acc.wr   = req & io_addr & wb.we;
  assign acc.rd   = req & io_addr & ~wb.we;
  assign acc.off  = wb.adr[7:0];
  assign acc.data = wb.dat;

  // blocks that miss contribute nothing
  assign rd_data = (rsp_sw.hit  ? rsp_sw.data  : 8'h00) |
                   (rsp_lc.hit  ? rsp_lc.data  : 8'h00) |
                   (rsp_irq.hit ? rsp_irq.data : 8'h00);

  always_ff @(posedge clk_sys or posedge cpu_vda) begin
    if (cpu_vda) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;  // one cycle, never stalls
    end
  end

  always_ff @(posedge clk_sys) begin
    if (req & ~wb.we) begin
      wb_dat <= acc.rd ? rd_data : 8'h00;  // non-IO reads return 00
    end
  end

endmodule

`default_nettype wire

// File: softswitch_regs.sv
`timescale 1ns/1ns
`default_nettype none

module softswitch_regs (
  input  wire logic                    clk_sys,
  input  wire logic                    cpu_vda,
  input  wire iigs_glue_pkg::io_acc_t  acc,
  input  wire iigs_glue_pkg::lc_ctl_t  lc,
  input  wire logic                    vblank,
  output iigs_glue_pkg::mem_mode_t     mode,
  output logic [7:0]                   shadow,
  output iigs_glue_pkg::io_rsp_t       rsp
);
  import iigs_glue_pkg::*;

  logic [15:0] flags;  // status bit 7 for C010..C01F

  always_ff @(posedge clk_sys or posedge cpu_vda) begin
    if (cpu_vda) begin
      mode   <= '0;
      shadow <= SHADOW_RESET;
    end else begin
      if (acc.wr) begin
        case (acc.off)  // even offset clears, odd sets
          REG_STORE80_OFF, REG_STORE80_ON: mode.store80    <= acc.off[0];
          REG_RAMRD_OFF, REG_RAMRD_ON:     mode.ramrd      <= acc.off[0];
          REG_RAMWRT_OFF, REG_RAMWRT_ON:   mode.ramwrt     <= acc.off[0];
          REG_INTCX_OFF, REG_INTCX_ON:     mode.intcxrom   <= acc.off[0];
          REG_ALTZP_OFF, REG_ALTZP_ON:     mode.altzp      <= acc.off[0];
          REG_SLOTC3_OFF, REG_SLOTC3_ON:   mode.slotc3rom  <= acc.off[0];
          REG_80COL_OFF, REG_80COL_ON:     mode.eightycol  <= acc.off[0];
          REG_ALTCHR_OFF, REG_ALTCHR_ON:   mode.altcharset <= acc.off[0];
          REG_SHADOW:                      shadow          <= acc.data;
          default: ;
        endcase
      end
      // video switches toggle on reads as well
      if (acc.wr | acc.rd) begin
        case (acc.off)
          REG_TEXT_OFF, REG_TEXT_ON:   mode.textg <= acc.off[0];
          REG_MIXED_OFF, REG_MIXED_ON: mode.mixg  <= acc.off[0];
          REG_PAGE2_OFF, REG_PAGE2_ON: mode.page2 <= acc.off[0];
          REG_HIRES_OFF, REG_HIRES_ON: mode.hires <= acc.off[0];
          default: ;
        endcase
      end
    end
  end

  assign flags = {mode.eightycol, mode.altcharset, ~mode.hires, mode.page2,
                  mode.mixg, mode.textg, ~vblank, mode.store80,
                  mode.slotc3rom, mode.altzp, mode.intcxrom, mode.ramwrt,
                  mode.ramrd, ~lc.rdrom, lc.lcram2, 1'b0};

  always_comb begin
    rsp = '0;
    if (acc.off[7:4] == 4'h1 && acc.off[3:0] != 4'h0) begin
      rsp.hit  = 1'b1;
      rsp.data = {flags[acc.off[3:0]], 7'b0000000};  // low bits belong to the keyboard
    end else if (acc.off == REG_SHADOW) begin
      rsp.hit  = 1'b1;
      rsp.data = shadow;
    end else if (acc.off == REG_STATE) begin
      rsp.hit  = 1'b1;
      rsp.data = {mode.altzp, mode.page2, mode.ramrd, mode.ramwrt,
                  lc.rdrom, lc.lcram2, mode.rombank, mode.intcxrom};
    end
  end

endmodule

`default_nettype wire

// File: lang_card_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module lang_card_fsm (
  input  wire logic                    clk_sys,
  input  wire logic                    cpu_vda,
  input  wire iigs_glue_pkg::io_acc_t  acc,
  output iigs_glue_pkg::lc_ctl_t       lc,
  output iigs_glue_pkg::io_rsp_t       rsp
);
  import iigs_glue_pkg::*;

  lc_state_e state;
  logic      rdrom_q;
  logic      lcram2_q;
  logic      lc_acc;

  assign lc_acc = (acc.wr | acc.rd) && ((acc.off & 8'hF0) == REG_LC_BASE);

  always_ff @(posedge clk_sys or posedge cpu_vda) begin
    if (cpu_vda) begin
      state    <= lc_protect;
      rdrom_q  <= 1'b1;
      lcram2_q <= 1'b0;
    end else if (lc_acc) begin
      rdrom_q  <= acc.off[0] ^ acc.off[1];  // 81/82 read ROM
      lcram2_q <= ~acc.off[3];              // 80..87 pick bank 2
      if (acc.rd & acc.off[0]) begin
        case (state)
          lc_protect: state <= lc_armed;
          default:    state <= lc_write;  // second odd read unlocks
        endcase
      end else begin
        state <= lc_protect;  // even read or any write
      end
    end
  end

  assign lc = '{rdrom: rdrom_q, lcram2: lcram2_q, lc_we: state == lc_write};

  // switch reads return floating bus
  assign rsp = '0;

endmodule

`default_nettype wire

// File: aux_mapper.sv
`timescale 1ns/1ns
`default_nettype none

module aux_mapper (
  input  wire logic [23:0]               adr,
  input  wire logic                      we,
  input  wire iigs_glue_pkg::mem_mode_t  mode,
  input  wire iigs_glue_pkg::lc_ctl_t    lc,
  input  wire logic [7:0]                shadow,
  output logic [23:0]                    phys_addr
);
  import iigs_glue_pkg::*;

  logic [7:0]  bank;
  logic [15:0] a;
  logic        rw_aux;   // RAMRD/RAMWRT by direction
  logic        aux;
  logic        in_lc;
  logic        lc_hit;

  assign bank   = adr[23:16];
  assign a      = adr[15:0];
  assign rw_aux = we ? mode.ramwrt : mode.ramrd;

  always_comb begin
    aux = 1'b0;
    if (bank == BANK_MAIN || bank == BANK_MEGA) begin
      if (a[15:9] == 7'h00 || a[15:14] == 2'b11) begin
        aux = mode.altzp;  // zero page, stack, C0-FF
      end else if (a[15:10] == 6'b000001) begin
        aux = mode.store80 ? mode.page2 : rw_aux;  // text page 1
      end else if (a[15:13] == 3'b001) begin
        aux = (mode.store80 & mode.hires) ? mode.page2 : rw_aux;  // hires page 1
      end else begin
        aux = rw_aux;
      end
    end
  end

  assign in_lc  = (a >= LC_LO) && (a <= LC_HI);
  // bank 2 sits 4K below D000
  assign lc_hit = in_lc & lc.lcram2 & ~lc.rdrom &
                  ((bank == BANK_MEGA || bank == BANK_MEGA1) |
                   ((bank == BANK_MAIN || bank == BANK_MAIN1) & ~shadow[SHADOW_IO_BIT]));

  assign phys_addr = adr - (lc_hit ? LC_OFFSET : 24'h000000) + (aux ? AUX_OFFSET : 24'h000000);

endmodule

`default_nettype wire

// File: irq_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module irq_ctrl (
  input  wire logic                    clk_sys,
  input  wire logic                    cpu_vda,
  input  wire iigs_glue_pkg::io_acc_t  acc,
  input  wire logic                    scanline_irq,
  input  wire logic                    vbl_irq,
  input  wire logic                    qtr_tick,
  input  wire logic                    sec_tick,
  output logic                         irq,
  output iigs_glue_pkg::io_rsp_t       rsp
);
  import iigs_glue_pkg::*;

  logic [7:0] vgcint;    // 7 any, 6 second, 5 scanline, 2:1 enables
  logic [4:0] inten;
  logic       vbl_flag;  // INTFLAG bit 3
  logic       qtr_flag;  // INTFLAG bit 4
  logic       clr_both;
  logic [7:0] intflag;

  assign clr_both = (~vgcint[5] | ~acc.data[5]) & (~vgcint[6] | ~acc.data[6]);

  always_ff @(posedge clk_sys or posedge cpu_vda) begin
    if (cpu_vda) begin
      vgcint   <= 8'h00;
      inten    <= 5'h00;
      vbl_flag <= 1'b0;
      qtr_flag <= 1'b0;
    end else begin
      if (acc.wr) begin
        case (acc.off)
          REG_VGCINT: vgcint[2:1] <= acc.data[2:1];
          REG_VGCCLR: begin  // zero bits clear
            if (!acc.data[5]) vgcint[5] <= 1'b0;
            if (!acc.data[6]) vgcint[6] <= 1'b0;
            if (clr_both) vgcint[7] <= 1'b0;
          end
          REG_INTEN:  inten <= acc.data[4:0];
          default: ;
        endcase
      end
      if ((acc.wr | acc.rd) && acc.off == REG_INTCLR) begin
        vbl_flag <= 1'b0;
        qtr_flag <= 1'b0;
      end
      // sources after clears so a same-cycle event is kept
      if (scanline_irq) begin
        vgcint[5] <= 1'b1;
        if (vgcint[1]) vgcint[7] <= 1'b1;
      end
      if (sec_tick & vgcint[2]) begin
        vgcint[6] <= 1'b1;
        vgcint[7] <= 1'b1;
      end
      if (vbl_irq & inten[3]) vbl_flag <= 1'b1;
      if (qtr_tick & inten[4]) qtr_flag <= 1'b1;
    end
  end

  assign intflag = {3'b000, qtr_flag, vbl_flag, 2'b00,
                    qtr_flag | vbl_flag | vgcint[6] | vgcint[7]};

  assign irq = (vgcint[6] & vgcint[2]) | (vgcint[5] & vgcint[1]) |
               (inten[3] & vbl_flag) | (inten[4] & qtr_flag);

  always_comb begin
    rsp = '0;
    case (acc.off)
      REG_VGCINT:  rsp = '{hit: 1'b1, data: vgcint};
      REG_INTEN:   rsp = '{hit: 1'b1, data: {3'b000, inten}};
      REG_INTFLAG: rsp = '{hit: 1'b1, data: intflag};
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: tick_timer.sv
`timescale 1ns/1ns
`default_nettype none

module tick_timer (
  input  wire logic clk_sys,
  input  wire logic cpu_vda,
  output logic      qtr_tick,
  output logic      sec_tick
);
  import iigs_glue_pkg::*;

  qtr_cnt_t   cyc_cnt;
  logic [1:0] qtr_cnt;  // quarters within the second
  logic       qtr_last;

  assign qtr_last = (cyc_cnt == qtr_cnt_t'(QTR_TICK_CYCLES - 1));

  always_ff @(posedge clk_sys or posedge cpu_vda) begin
    if (cpu_vda) begin
      cyc_cnt  <= '0;
      qtr_cnt  <= 2'd0;
      qtr_tick <= 1'b0;
      sec_tick <= 1'b0;
    end else begin
      cyc_cnt  <= qtr_last ? '0 : cyc_cnt + 1'b1;
      qtr_tick <= qtr_last;
      sec_tick <= qtr_last && (qtr_cnt == 2'(QTRS_PER_SECOND - 1));
      if (qtr_last) begin
        qtr_cnt <= (qtr_cnt == 2'(QTRS_PER_SECOND - 1)) ? 2'd0 : qtr_cnt + 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: iigs_glue.sv
`timescale 1ns/1ns
`default_nettype none

module iigs_glue (
  input  wire logic                    clk_sys,
  input  wire logic                    cpu_vda,
  input  wire iigs_glue_pkg::wb_req_t  wb,
  output logic [7:0]                   wb_dat,
  output logic                         wb_ack,
  input  wire logic                    vblank,
  input  wire logic                    scanline_irq,
  input  wire logic                    vbl_irq,
  output iigs_glue_pkg::mem_out_t      mem,
  output logic                         irq
);
  import iigs_glue_pkg::*;

  io_acc_t     acc;
  io_rsp_t     rsp_sw;
  io_rsp_t     rsp_lc;
  io_rsp_t     rsp_irq;
  mem_mode_t   mode;
  lc_ctl_t     lc;
  logic [7:0]  shadow;
  logic [23:0] phys_addr;
  logic        io;
  logic        qtr_tick;
  logic        sec_tick;

  assign mem = '{phys_addr: phys_addr, io: io, lc_we: lc.lc_we};

  wb_io_port wb_io_port_i (
    .clk_sys(clk_sys), .cpu_vda(cpu_vda), .wb(wb), .shadow(shadow),
    .rsp_sw(rsp_sw), .rsp_lc(rsp_lc), .rsp_irq(rsp_irq),
    .acc(acc), .wb_dat(wb_dat), .wb_ack(wb_ack), .io(io)
  );

  softswitch_regs softswitch_regs_i (
    .clk_sys(clk_sys), .cpu_vda(cpu_vda), .acc(acc), .lc(lc), .vblank(vblank),
    .mode(mode), .shadow(shadow), .rsp(rsp_sw)
  );

  lang_card_fsm lang_card_fsm_i (
    .clk_sys(clk_sys), .cpu_vda(cpu_vda), .acc(acc), .lc(lc), .rsp(rsp_lc)
  );

  aux_mapper aux_mapper_i (
    .adr(wb.adr), .we(wb.we), .mode(mode), .lc(lc), .shadow(shadow),
    .phys_addr(phys_addr)
  );

  irq_ctrl irq_ctrl_i (
    .clk_sys(clk_sys), .cpu_vda(cpu_vda), .acc(acc),
    .scanline_irq(scanline_irq), .vbl_irq(vbl_irq),
    .qtr_tick(qtr_tick), .sec_tick(sec_tick), .irq(irq), .rsp(rsp_irq)
  );

  tick_timer tick_timer_i (
    .clk_sys(clk_sys), .cpu_vda(cpu_vda), .qtr_tick(qtr_tick), .sec_tick(sec_tick)
  );

endmodule

`default_nettype wire

// File: tb_iigs_glue_tasks.svh
`ifndef TB_IIGS_GLUE_TASKS_SVH
`define TB_IIGS_GLUE_TASKS_SVH

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return {16'h0000, lcg_state[31:16]};  // upper half spreads better
endfunction

task automatic report_error(input string msg);
  err_count++;
  $display("%s", msg);
  $display("=== FAIL ===");
  $fatal(1, "stopped at first error");
endtask

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
  if (got !== exp) begin
    report_error($sformatf("Error at %0t ns: %s is %02h, expected %02h",
                           $time, name, got, exp));
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    report_error($sformatf("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp));
  end
endtask

task automatic check_mem(input string name, input mem_out_t got, input mem_out_t exp);
  if (got !== exp) begin
    report_error($sformatf("Error at %0t ns: %s is %06h/io %b/we %b, expected %06h/io %b/we %b",
                           $time, name, got.phys_addr, got.io, got.lc_we,
                           exp.phys_addr, exp.io, exp.lc_we));
  end
endtask

function automatic mem_out_t make_mem(input logic [23:0] phys, input logic io,
                                      input logic we);
  mem_out_t m;
  m.phys_addr = phys;
  m.io        = io;
  m.lc_we     = we;
  return m;
endfunction

function automatic logic [23:0] io_adr(input logic [7:0] off);
  return {BANK_MAIN, IO_PAGE, off};
endfunction

task automatic idle(input int n);
  repeat (n) @(posedge clk_sys);
  #1;
endtask

task automatic apply_reset();
  cpu_vda = 1'b1;
  wb      = '0;
  repeat (2) @(posedge clk_sys);
  #1;
  cpu_vda      = 1'b0;
  m_mode       = '0;
  m_lc.rdrom   = 1'b1;
  m_lc.lcram2  = 1'b0;
  m_lc.lc_we   = 1'b0;
  m_odd        = 0;
  m_shadow     = SHADOW_RESET;
endtask

// one classic cycle with mem sampled while the request is on the bus
task automatic bus_access(input logic we, input logic [23:0] adr, input logic [7:0] dat,
                          output logic [7:0] rdata, output mem_out_t seen);
  int waited;
  wb.cyc = 1'b1;
  wb.stb = 1'b1;
  wb.we  = we;
  wb.adr = adr;
  wb.dat = dat;
  #1;
  seen = mem;
  check_bit("wb_ack", wb_ack, 1'b0);  // no ack before the clock edge
  @(posedge clk_sys);
  #1;
  waited = 1;
  while (!wb_ack && waited < ACK_LIMIT) begin
    @(posedge clk_sys);
    #1;
    waited++;
  end
  if (!wb_ack) begin
    report_error($sformatf("no ack for address %06h within %0d cycles", adr, ACK_LIMIT));
  end
  if (waited != 1) begin
    report_error($sformatf("ack for address %06h came after %0d cycles, not 1", adr, waited));
  end
  rdata = wb_dat;
  wb    = '0;
  @(posedge clk_sys);
  #1;
  check_bit("wb_ack", wb_ack, 1'b0);  // single-cycle ack
endtask

task automatic wb_write(input logic [23:0] adr, input logic [7:0] dat);
  logic [7:0] rd;
  mem_out_t   seen;
  bus_access(1'b1, adr, dat, rd, seen);
endtask

task automatic wb_read(input logic [23:0] adr, output logic [7:0] rd);
  mem_out_t seen;
  bus_access(1'b0, adr, 8'h00, rd, seen);
endtask

function automatic logic status_flag(input logic [3:0] idx);
  case (idx)
    4'h1: return m_lc.lcram2;
    4'h2: return ~m_lc.rdrom;
    4'h3: return m_mode.ramrd;
    4'h4: return m_mode.ramwrt;
    4'h5: return m_mode.intcxrom;
    4'h6: return m_mode.altzp;
    4'h7: return m_mode.slotc3rom;
    4'h8: return m_mode.store80;
    4'h9: return ~vblank;
    4'hA: return m_mode.textg;
    4'hB: return m_mode.mixg;
    4'hC: return m_mode.page2;
    4'hD: return ~m_mode.hires;
    4'hE: return m_mode.altcharset;
    default: return m_mode.eightycol;
  endcase
endfunction

function automatic logic [7:0] state_byte();
  return {m_mode.altzp, m_mode.page2, m_mode.ramrd, m_mode.ramwrt,
          m_lc.rdrom, m_lc.lcram2, m_mode.rombank, m_mode.intcxrom};
endfunction

// aux and language-card translation from the memory map rules
function automatic logic [23:0] expect_phys(input logic [23:0] adr, input logic we);
  logic [7:0]  bank;
  logic [7:0]  page;
  logic        dir_sel;
  logic        aux;
  logic        lc_bank;
  logic [23:0] phys;
  bank    = adr[23:16];
  page    = adr[15:8];
  dir_sel = we ? m_mode.ramwrt : m_mode.ramrd;
  aux     = 1'b0;
  if (bank == BANK_MAIN || bank == BANK_MEGA) begin
    if (page <= 8'h01 || page >= 8'hC0) begin
      aux = m_mode.altzp;
    end else if (page >= 8'h04 && page <= 8'h07) begin
      aux = m_mode.store80 ? m_mode.page2 : dir_sel;
    end else if (page >= 8'h20 && page <= 8'h3F) begin
      aux = (m_mode.store80 && m_mode.hires) ? m_mode.page2 : dir_sel;
    end else begin
      aux = dir_sel;
    end
  end
  lc_bank = (bank == BANK_MEGA || bank == BANK_MEGA1) ||
            ((bank == BANK_MAIN || bank == BANK_MAIN1) && !m_shadow[SHADOW_IO_BIT]);
  phys = adr;
  if (page >= LC_LO[15:8] && page <= LC_HI[15:8] && m_lc.lcram2 && !m_lc.rdrom && lc_bank) begin
    phys = phys - LC_OFFSET;
  end
  if (aux) begin
    phys = phys + AUX_OFFSET;
  end
  return phys;
endfunction

function automatic logic expect_io(input logic [23:0] adr);
  logic bank_ok;
  bank_ok = adr[23:16] == BANK_MAIN || adr[23:16] == BANK_MAIN1 ||
            adr[23:16] == BANK_MEGA || adr[23:16] == BANK_MEGA1;
  return bank_ok && adr[15:8] == IO_PAGE && !m_shadow[SHADOW_IO_BIT];
endfunction

task automatic switch_write(input logic [7:0] off);
  wb_write(io_adr(off), 8'h00);
  if (off[7:4] == 4'h0) begin
    case (off[3:1])  // odd offset of each pair sets
      3'd0: m_mode.store80    = off[0];
      3'd1: m_mode.ramrd      = off[0];
      3'd2: m_mode.ramwrt     = off[0];
      3'd3: m_mode.intcxrom   = off[0];
      3'd4: m_mode.altzp      = off[0];
      3'd5: m_mode.slotc3rom  = off[0];
      3'd6: m_mode.eightycol  = off[0];
      default: m_mode.altcharset = off[0];
    endcase
  end else begin
    case (off[2:1])
      2'd0: m_mode.textg = off[0];
      2'd1: m_mode.mixg  = off[0];
      2'd2: m_mode.page2 = off[0];
      default: m_mode.hires = off[0];
    endcase
  end
endtask

task automatic check_status_reg(input logic [7:0] off);
  logic [7:0] rd;
  logic [7:0] exp;
  wb_read(io_adr(off), rd);
  if (off == REG_STATE) begin
    exp = state_byte();
  end else begin
    exp = {status_flag(off[3:0]), 7'b0000000};
  end
  check_byte($sformatf("read C0%02h", off), rd, exp);
endtask

task automatic check_all_status();
  int o;
  for (o = 'h11; o <= 'h1F; o++) begin
    check_status_reg(8'(o));
  end
  check_status_reg(REG_STATE);
endtask

task automatic lc_access(input logic we, input logic [3:0] low);
  logic [7:0] rd;
  if (we) begin
    wb_write(io_adr({4'h8, low}), 8'h00);
  end else begin
    wb_read(io_adr({4'h8, low}), rd);
  end
  m_lc.rdrom  = low[0] ^ low[1];
  m_lc.lcram2 = ~low[3];
  if (!we && low[0]) begin
    m_odd = (m_odd < 2) ? m_odd + 1 : 2;
  end else begin
    m_odd = 0;
  end
  m_lc.lc_we = (m_odd == 2);
  check_bit("mem.lc_we", mem.lc_we, m_lc.lc_we);
  check_status_reg(8'h11);
  check_status_reg(8'h12);
endtask

task automatic map_probe(input logic we, input logic [23:0] adr);
  logic [7:0] rd;
  mem_out_t   seen;
  bus_access(we, adr, 8'h00, rd, seen);
  check_mem("mem", seen, make_mem(expect_phys(adr, we), expect_io(adr), m_lc.lc_we));
endtask

task automatic pulse_irq_source(input logic use_vbl);
  if (use_vbl) begin
    vbl_irq = 1'b1;
  end else begin
    scanline_irq = 1'b1;
  end
  idle(1);
  vbl_irq      = 1'b0;
  scanline_irq = 1'b0;
  idle(1);
endtask

task automatic test_bus_timing();
  logic [7:0] rd;
  apply_reset();
  wb_write(24'h021234, 8'h5A);
  wb_read(24'h021234, rd);
  check_byte("read 02:1234", rd, 8'h00);
  idle(3);  // gap between requests
  wb_read(io_adr(8'h10), rd);
  check_byte("read C010", rd, 8'h00);
  wb_write({BANK_MEGA1, 16'h4000}, 8'hFF);
  wb_read({BANK_MEGA, IO_PAGE, 8'h70}, rd);
  check_byte("read E0:C070", rd, 8'h00);
endtask

task automatic test_soft_switches();
  logic [31:0] r;
  logic [7:0]  val;
  logic [7:0]  rd;
  int          i;
  apply_reset();
  check_all_status();
  for (i = 0; i < SW_STEPS; i++) begin
    r      = lcg_next();
    vblank = r[8];
    switch_write(r[0] ? {4'h0, r[4:1]} : {5'b01010, r[3:1]});
    check_all_status();
  end
  r   = lcg_next();
  val = r[7:0] & 8'hBF;  // keep IO visible
  wb_write(io_adr(REG_SHADOW), val);
  m_shadow = val;
  wb_read(io_adr(REG_SHADOW), rd);
  check_byte("read C035", rd, m_shadow);
  vblank = 1'b0;
endtask

task automatic test_lang_card();
  apply_reset();
  lc_access(1'b0, 4'h3);
  lc_access(1'b0, 4'h3);  // second odd read unlocks
  lc_access(1'b0, 4'h0);
  lc_access(1'b0, 4'hB);
  lc_access(1'b0, 4'hB);
  lc_access(1'b1, 4'hB);
  lc_access(1'b0, 4'h1);
  lc_access(1'b0, 4'h9);
  lc_access(1'b0, 4'h9);
endtask

task automatic test_address_map();
  logic [31:0] r;
  logic [23:0] adr;
  logic [7:0]  bank;
  logic [3:0]  lo;
  int          k;
  int          i;
  apply_reset();
  for (k = 0; k < MAP_ROUNDS; k++) begin
    for (i = 0; i < 6; i++) begin
      r = lcg_next();
      switch_write(r[0] ? {4'h0, r[4:1]} : {5'b01010, r[3:1]});
    end
    r  = lcg_next();
    lo = (k == 0) ? 4'h3 : r[3:0];  // first round maps LC bank 2
    lc_access(1'b0, lo);
    lc_access(1'b0, lo);
    for (i = 0; i < MAP_PROBES; i++) begin
      r = lcg_next();
      r = (r << 16) | lcg_next();  // two draws fill all 32 bits
      case (r[1:0])
        2'd0: bank = BANK_MAIN;
        2'd1: bank = BANK_MAIN1;
        2'd2: bank = BANK_MEGA;
        default: bank = BANK_MEGA1;
      endcase
      adr = {bank, r[2] ? {4'hD, r[6:3]} : r[10:3], r[18:11]};
      if (adr[15:8] == IO_PAGE) begin
        adr[15:8] = 8'hC1;  // IO page has side effects
      end
      map_probe(r[19], adr);
    end
  end
  map_probe(1'b0, io_adr(8'h10));
  map_probe(1'b0, {BANK_MEGA1, IO_PAGE, 8'h10});
  map_probe(1'b0, {8'h02, IO_PAGE, 8'h10});
  lc_access(1'b0, 4'h3);
  wb_write(io_adr(REG_SHADOW), 8'h48);
  m_shadow = 8'h48;
  map_probe(1'b0, io_adr(8'h10));  // shadowed out of IO
  map_probe(1'b0, 24'h00D123);
  map_probe(1'b1, 24'hE0D456);
  map_probe(1'b0, 24'h01DABC);
endtask

task automatic test_interrupts();
  logic [7:0] rd;
  apply_reset();
  pulse_irq_source(1'b0);
  check_bit("irq", irq, 1'b0);
  wb_read(io_adr(REG_VGCINT), rd);
  check_byte("read C023", rd, 8'h20);
  wb_write(io_adr(REG_VGCCLR), 8'h00);
  wb_read(io_adr(REG_VGCINT), rd);
  check_byte("read C023", rd, 8'h00);
  wb_write(io_adr(REG_VGCINT), 8'h02);
  pulse_irq_source(1'b0);
  check_bit("irq", irq, 1'b1);
  wb_read(io_adr(REG_VGCINT), rd);
  check_byte("read C023", rd, 8'hA2);
  wb_read(io_adr(REG_INTFLAG), rd);
  check_byte("read C046", rd, 8'h01);
  wb_write(io_adr(REG_VGCCLR), 8'h00);
  check_bit("irq", irq, 1'b0);
  wb_read(io_adr(REG_VGCINT), rd);
  check_byte("read C023", rd, 8'h02);
  wb_write(io_adr(REG_INTEN), 8'h08);
  pulse_irq_source(1'b1);
  check_bit("irq", irq, 1'b1);
  wb_read(io_adr(REG_INTFLAG), rd);
  check_byte("read C046", rd, 8'h09);
  wb_read(io_adr(REG_INTCLR), rd);
  wb_read(io_adr(REG_INTFLAG), rd);
  check_byte("read C046", rd, 8'h00);
  check_bit("irq", irq, 1'b0);
endtask

task automatic test_timer_irq();
  logic [7:0] rd;
  apply_reset();
  wb_write(io_adr(REG_VGCINT), 8'h04);
  wb_write(io_adr(REG_INTEN), 8'h10);
  idle(SECOND_CYCLES + 2);
  check_bit("irq", irq, 1'b1);
  wb_read(io_adr(REG_VGCINT), rd);
  check_byte("read C023", rd, 8'hC4);
  wb_read(io_adr(REG_INTFLAG), rd);
  check_byte("read C046", rd, 8'h11);
  apply_reset();
  idle(SECOND_CYCLES + 2);  // enables clear this time
  check_bit("irq", irq, 1'b0);
  wb_read(io_adr(REG_VGCINT), rd);
  check_byte("read C023", rd, 8'h00);
  wb_read(io_adr(REG_INTFLAG), rd);
  check_byte("read C046", rd, 8'h00);
endtask

`endif

// File: tb_iigs_glue.sv
`timescale 1ns/1ns
`default_nettype none

module tb_iigs_glue;
  import iigs_glue_pkg::*;

  localparam int CLK_PERIOD    = 20;
  localparam int SW_STEPS      = 12;
  localparam int MAP_ROUNDS    = 4;
  localparam int MAP_PROBES    = 10;  // per round
  localparam int ACK_LIMIT     = 16;
  localparam int SECOND_CYCLES = QTR_TICK_CYCLES * QTRS_PER_SECOND;

  // rough cycle count of each test, two cycles per bus access
  localparam int TEST_CYCLES = 30 + SW_STEPS * 40 + 9 * 12
                             + MAP_ROUNDS * (40 + MAP_PROBES * 2) + 60
                             + 60 + 2 * (SECOND_CYCLES + 20);
  localparam int WATCHDOG_NS = (20 * TEST_CYCLES + 8 * SECOND_CYCLES) * CLK_PERIOD;

  logic       clk_sys = 1'b0;
  logic       cpu_vda;
  wb_req_t    wb;
  logic [7:0] wb_dat;
  logic       wb_ack;
  logic       vblank;
  logic       scanline_irq;
  logic       vbl_irq;
  mem_out_t   mem;
  logic       irq;

  // reference model state
  mem_mode_t   m_mode;
  lc_ctl_t     m_lc;
  int          m_odd;  // odd LC reads in a row
  logic [7:0]  m_shadow;
  logic [31:0] lcg_state = 32'd35;
  int          err_count = 0;

  always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

  iigs_glue iigs_glue_i (
    .clk_sys(clk_sys),
    .cpu_vda(cpu_vda),
    .wb(wb),
    .wb_dat(wb_dat),
    .wb_ack(wb_ack),
    .vblank(vblank),
    .scanline_irq(scanline_irq),
    .vbl_irq(vbl_irq),
    .mem(mem),
    .irq(irq)
  );

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the test sequence did not finish", WATCHDOG_NS);
    $display("=== FAIL ===");
    $fatal(1, "timeout");
  end

  initial begin
    cpu_vda      = 1'b1;
    wb           = '0;
    vblank       = 1'b0;
    scanline_irq = 1'b0;
    vbl_irq      = 1'b0;
    test_bus_timing();
    test_soft_switches();
    test_lang_card();
    test_address_map();
    test_interrupts();
    test_timer_irq();
    if (err_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  `include "tb_iigs_glue_tasks.svh"

endmodule

`default_nettype wire

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_iigs_glue
FILELIST  ?= iigs_glue.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ns

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "=== PASS ==="

clean:
	rm -rf $(OBJ_DIR)

// File: iigs_glue.f
+incdir+.
iigs_glue_pkg.sv
wb_io_port.sv
softswitch_regs.sv
lang_card_fsm.sv
aux_mapper.sv
irq_ctrl.sv
tick_timer.sv
iigs_glue.sv
tb_iigs_glue.sv
